// File: source/rv32i_types_pkg.sv
////////////////////////////////////////////////////////////
// RV32I instruction-side types.
// Word and address widths shared by the fetch path,
// the predictor and the instruction memory, plus the
// default program counter after reset.
////////////////////////////////////////////////////////////

`default_nettype none

package rv32i_types_pkg;

  // Data or instruction word.
  typedef logic [31:0] word_t;

  // Byte address.
  typedef logic [31:0] addr_t;

  // Boot address of the core.
  // Word aligned, inside the default instruction memory.
  localparam addr_t RESET_PC = 32'h0000_0200;

endpackage

`default_nettype wire

// File: source/imem_bus_pkg.sv
////////////////////////////////////////////////////////////
// Instruction memory bus types.
// Byte enable of the shared memory port and the owner
// encoding of the fetch/load arbiter.
////////////////////////////////////////////////////////////

`default_nettype none

package imem_bus_pkg;

  // One enable bit per byte lane, bit 0 is the low byte.
  typedef logic [3:0] byte_en_t;

  // Arbiter owner.
  // IDLE means no access is in progress.
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    LOAD
  } arb_owner_t;

endpackage

`default_nettype wire

// File: source/instr_ram.sv
////////////////////////////////////////////////////////////
// Instruction RAM.
// Word array with byte-enabled writes. Every access takes
// RAM_WAIT wait states, signalled by busy, and completes
// in the first cycle with busy low and the request held.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instr_ram #(
  parameter int RAM_WORDS = 256,
  parameter int RAM_WAIT  = 1
) (
  input  wire                     CLK,
  input  wire                     nRST,
  input  wire rv32i_types_pkg::addr_t   addr,
  input  wire                     ren,
  input  wire                     wen,
  input  wire imem_bus_pkg::byte_en_t   byte_en,
  input  wire rv32i_types_pkg::word_t   wdata,
  output rv32i_types_pkg::word_t  rdata,
  output logic                    busy
);

  // Counter must hold the value RAM_WAIT.
  localparam int CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;
  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(RAM_WAIT);

  rv32i_types_pkg::word_t mem [RAM_WORDS];

  logic             req;
  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] word_idx;

  assign req = ren | wen;

  // Word index, byte offset dropped.
  assign word_idx = addr[IDX_W+1:2];

  // Busy until the wait states have elapsed.
  assign busy = req && (wait_cnt != WAIT_LAST);

  // Asynchronous read of the addressed word.
  assign rdata = mem[word_idx];

  // Wait-state counter.
  // Restarts when the request drops or completes.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!req || !busy) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Write lands at the end of the completing cycle.
  always_ff @(posedge CLK) begin
    if (wen && !busy) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b]) begin
          mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Arbiter must never present a read and a write at once.
  a_no_rw_overlap: assert property (@(posedge CLK) disable iff (!nRST)
    !(ren && wen));

endmodule

`default_nettype wire

// File: source/imem_arbiter.sv
////////////////////////////////////////////////////////////
// Instruction memory arbiter.
// Shares one memory port between the fetch stage and the
// program-load port. Load wins a free port, a grant lasts
// until its access completes, and the losing peer sees busy.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module imem_arbiter (
  input  wire                           CLK,
  input  wire                           nRST,
  // Fetch peer, always requesting a read.
  input  wire rv32i_types_pkg::addr_t   fetch_addr,
  output rv32i_types_pkg::word_t        fetch_rdata,
  output logic                          fetch_busy,
  // Load peer, full-word writes.
  input  wire                           load_en,
  input  wire rv32i_types_pkg::addr_t   load_addr,
  input  wire rv32i_types_pkg::word_t   load_data,
  output logic                          load_busy,
  // Memory side.
  output rv32i_types_pkg::addr_t        ram_addr,
  output logic                          ram_ren,
  output logic                          ram_wen,
  output imem_bus_pkg::byte_en_t        ram_byte_en,
  output rv32i_types_pkg::word_t        ram_wdata,
  input  wire rv32i_types_pkg::word_t   ram_rdata,
  input  wire                           ram_busy
);

  imem_bus_pkg::arb_owner_t owner;
  imem_bus_pkg::arb_owner_t grant;

  // Peer served this cycle.
  // A pending access keeps its owner, a free port goes to load first.
  always_comb begin
    if (owner != imem_bus_pkg::IDLE) begin
      grant = owner;
    end else if (load_en) begin
      grant = imem_bus_pkg::LOAD;
    end else begin
      grant = imem_bus_pkg::FETCH;
    end
  end

  // Owner FSM.
  // Released in the cycle the access completes.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      owner <= imem_bus_pkg::IDLE;
    end else if (ram_busy) begin
      owner <= grant;
    end else begin
      owner <= imem_bus_pkg::IDLE;
    end
  end

  // Request path.
  always_comb begin
    if (grant == imem_bus_pkg::LOAD) begin
      ram_addr    = load_addr;
      ram_ren     = 1'b0;
      ram_wen     = load_en;
      ram_byte_en = 4'hF;
      ram_wdata   = load_data;
    end else begin
      ram_addr    = fetch_addr;
      ram_ren     = 1'b1;
      ram_wen     = 1'b0;
      ram_byte_en = 4'h0;
      ram_wdata   = '0;
    end
  end

  // Response path.
  // Peer without the grant is held off with busy.
  assign fetch_rdata = (grant == imem_bus_pkg::FETCH) ? ram_rdata : '0;
  assign fetch_busy  = (grant == imem_bus_pkg::FETCH) ? ram_busy : 1'b1;
  assign load_busy   = (grant == imem_bus_pkg::LOAD) ? ram_busy : 1'b1;

  // Load peer holds its write until the memory completes it.
  a_load_held: assert property (@(posedge CLK) disable iff (!nRST)
    (ram_busy && grant == imem_bus_pkg::LOAD) |=> load_en);

endmodule

`default_nettype wire

// File: source/branch_target_buffer.sv
////////////////////////////////////////////////////////////
// Branch target buffer.
// Direct mapped, one 2-bit saturating counter per entry.
// Lookup is combinational from the fetch PC, updates from
// the execute stage are written at the clock edge.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
  parameter int BTB_ENTRIES = 16
) (
  input  wire                           CLK,
  input  wire                           nRST,
  input  wire rv32i_types_pkg::addr_t   current_pc,
  output logic                          predict_taken,
  output rv32i_types_pkg::addr_t        target_addr,
  input  wire                           update_en,
  input  wire rv32i_types_pkg::addr_t   update_pc,
  input  wire                           update_taken,
  input  wire rv32i_types_pkg::addr_t   update_target
);

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = 30 - IDX_W;

  logic [BTB_ENTRIES-1:0]  valid;
  logic [TAG_W-1:0]        tag_mem    [BTB_ENTRIES];
  rv32i_types_pkg::addr_t  target_mem [BTB_ENTRIES];
  logic [1:0]              cnt_mem    [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic             rd_hit;
  logic [IDX_W-1:0] up_idx;
  logic [TAG_W-1:0] up_tag;
  logic             up_hit;
  logic [1:0]       cnt_next;

  // Lookup.
  // Index above the byte offset, tag is the rest.
  assign rd_idx = current_pc[IDX_W+1:2];
  assign rd_tag = current_pc[31:IDX_W+2];
  assign rd_hit = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);

  // Weakly or strongly taken predicts taken.
  assign predict_taken = rd_hit && cnt_mem[rd_idx][1];
  assign target_addr   = target_mem[rd_idx];

  // Update entry.
  assign up_idx = update_pc[IDX_W+1:2];
  assign up_tag = update_pc[31:IDX_W+2];
  assign up_hit = valid[up_idx] && (tag_mem[up_idx] == up_tag);

  // New counter value.
  // Fresh entries start weakly taken or weakly not taken.
  always_comb begin
    if (!up_hit) begin
      cnt_next = update_taken ? 2'd2 : 2'd1;
    end else if (update_taken) begin
      cnt_next = (cnt_mem[up_idx] == 2'd3) ? 2'd3 : cnt_mem[up_idx] + 2'd1;
    end else begin
      cnt_next = (cnt_mem[up_idx] == 2'd0) ? 2'd0 : cnt_mem[up_idx] - 2'd1;
    end
  end

  // Valid bits.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (update_en) begin
      valid[up_idx] <= 1'b1;
    end
  end

  // Tag, target and counter storage.
  // A miss replaces the entry, a taken hit refreshes the target.
  always_ff @(posedge CLK) begin
    if (update_en) begin
      cnt_mem[up_idx] <= cnt_next;
      if (!up_hit) begin
        tag_mem[up_idx] <= up_tag;
      end
      if (!up_hit || update_taken) begin
        target_mem[up_idx] <= update_target;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
////////////////////////////////////////////////////////////
// Fetch stage of the two-stage pipeline.
// Holds the PC, picks the next PC from the privileged,
// branch, predicted and sequential sources, byte-swaps the
// fetched word and registers the fetch/execute record.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter rv32i_types_pkg::addr_t RESET_PC = 32'h0000_0200
) (
  input  wire                           CLK,
  input  wire                           nRST,
  // Instruction memory.
  output rv32i_types_pkg::addr_t        imem_addr,
  input  wire rv32i_types_pkg::word_t   imem_rdata,
  input  wire                           imem_busy,
  // Predictor.
  output rv32i_types_pkg::addr_t        current_pc,
  input  wire                           predict_taken,
  input  wire rv32i_types_pkg::addr_t   target_addr,
  // Redirects.
  input  wire rv32i_types_pkg::addr_t   brj_addr,
  input  wire                           npc_sel,
  input  wire rv32i_types_pkg::addr_t   priv_pc,
  input  wire                           insert_priv_pc,
  // Hazard controls.
  input  wire                           if_ex_stall,
  input  wire                           if_ex_flush,
  // Fetch/execute record.
  output logic                          fe_token,
  output rv32i_types_pkg::addr_t        fe_pc,
  output rv32i_types_pkg::addr_t        fe_pc4,
  output rv32i_types_pkg::word_t        fe_instr,
  output logic                          fe_prediction,
  // Fault.
  output logic                          mal_insn,
  output rv32i_types_pkg::addr_t        badaddr
);

  rv32i_types_pkg::addr_t pc;
  rv32i_types_pkg::addr_t pc4;
  rv32i_types_pkg::addr_t npc;
  rv32i_types_pkg::word_t instr;
  logic                   fetch_done;
  logic                   pc_en;

  assign pc4        = pc + 32'd4;
  assign imem_addr  = pc;
  assign current_pc = pc;

  // Access completes on busy low.
  assign fetch_done = !imem_busy;

  // Redirects move the PC at once, otherwise wait for the word.
  assign pc_en = insert_priv_pc || npc_sel || (fetch_done && !if_ex_stall);

  // Next PC, highest priority first.
  assign npc = insert_priv_pc ? priv_pc :
               npc_sel        ? brj_addr :
               predict_taken  ? target_addr : pc4;

  // Memory word is big endian relative to the core.
  assign instr = {imem_rdata[7:0], imem_rdata[15:8],
                  imem_rdata[23:16], imem_rdata[31:24]};

  // Program counter.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  // Fetch/execute register.
  // Flush beats stall. An unstalled cycle without a word inserts a bubble.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fe_token      <= 1'b0;
      fe_pc         <= RESET_PC;
      fe_pc4        <= '0;
      fe_instr      <= '0;
      fe_prediction <= 1'b0;
    end else if (if_ex_flush) begin
      fe_token      <= 1'b0;
      fe_pc         <= '0;
      fe_pc4        <= '0;
      fe_instr      <= '0;
      fe_prediction <= 1'b0;
    end else if (!if_ex_stall) begin
      if (fetch_done) begin
        fe_token      <= 1'b1;
        fe_pc         <= pc;
        fe_pc4        <= pc4;
        fe_instr      <= instr;
        fe_prediction <= predict_taken;
      end else begin
        fe_token <= 1'b0;
      end
    end
  end

  // Misaligned fetch address.
  assign mal_insn = (pc[1:0] != 2'b00);
  assign badaddr  = pc;

  // Flush only drops the wrong-path record behind a redirect.
  a_flush_with_redirect: assert property (@(posedge CLK) disable iff (!nRST)
    if_ex_flush |-> (npc_sel || insert_priv_pc));

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
////////////////////////////////////////////////////////////
// Instruction fetch subsystem.
// Fetch stage, branch target buffer, memory arbiter and
// instruction RAM. Execute-side controls come in at the
// ports, the fetch/execute record goes out.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter rv32i_types_pkg::addr_t RESET_PC = rv32i_types_pkg::RESET_PC,
  parameter int RAM_WORDS   = 256,
  parameter int RAM_WAIT    = 1,
  parameter int BTB_ENTRIES = 16
) (
  input  wire                           CLK,
  input  wire                           nRST,
  // Program load.
  input  wire                           load_en,
  input  wire rv32i_types_pkg::addr_t   load_addr,
  input  wire rv32i_types_pkg::word_t   load_data,
  output logic                          load_busy,
  // Redirects and hazard controls.
  input  wire rv32i_types_pkg::addr_t   brj_addr,
  input  wire                           npc_sel,
  input  wire rv32i_types_pkg::addr_t   priv_pc,
  input  wire                           insert_priv_pc,
  input  wire                           if_ex_stall,
  input  wire                           if_ex_flush,
  // Predictor training.
  input  wire                           update_en,
  input  wire rv32i_types_pkg::addr_t   update_pc,
  input  wire                           update_taken,
  input  wire rv32i_types_pkg::addr_t   update_target,
  // Fetch/execute record and fault.
  output logic                          fe_token,
  output rv32i_types_pkg::addr_t        fe_pc,
  output rv32i_types_pkg::addr_t        fe_pc4,
  output rv32i_types_pkg::word_t        fe_instr,
  output logic                          fe_prediction,
  output logic                          mal_insn,
  output rv32i_types_pkg::addr_t        badaddr
);

  // Fetch to arbiter.
  rv32i_types_pkg::addr_t fetch_addr;
  rv32i_types_pkg::word_t fetch_rdata;
  logic                   fetch_busy;

  // Fetch to predictor.
  rv32i_types_pkg::addr_t current_pc;
  logic                   predict_taken;
  rv32i_types_pkg::addr_t target_addr;

  // Arbiter to memory.
  rv32i_types_pkg::addr_t ram_addr;
  logic                   ram_ren;
  logic                   ram_wen;
  imem_bus_pkg::byte_en_t ram_byte_en;
  rv32i_types_pkg::word_t ram_wdata;
  rv32i_types_pkg::word_t ram_rdata;
  logic                   ram_busy;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) fetch_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .imem_addr      (fetch_addr),
    .imem_rdata     (fetch_rdata),
    .imem_busy      (fetch_busy),
    .current_pc     (current_pc),
    .predict_taken  (predict_taken),
    .target_addr    (target_addr),
    .brj_addr       (brj_addr),
    .npc_sel        (npc_sel),
    .priv_pc        (priv_pc),
    .insert_priv_pc (insert_priv_pc),
    .if_ex_stall    (if_ex_stall),
    .if_ex_flush    (if_ex_flush),
    .fe_token       (fe_token),
    .fe_pc          (fe_pc),
    .fe_pc4         (fe_pc4),
    .fe_instr       (fe_instr),
    .fe_prediction  (fe_prediction),
    .mal_insn       (mal_insn),
    .badaddr        (badaddr)
  );

  branch_target_buffer #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) btb_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .current_pc    (current_pc),
    .predict_taken (predict_taken),
    .target_addr   (target_addr),
    .update_en     (update_en),
    .update_pc     (update_pc),
    .update_taken  (update_taken),
    .update_target (update_target)
  );

  imem_arbiter arb_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .fetch_addr  (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .fetch_busy  (fetch_busy),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .load_busy   (load_busy),
    .ram_addr    (ram_addr),
    .ram_ren     (ram_ren),
    .ram_wen     (ram_wen),
    .ram_byte_en (ram_byte_en),
    .ram_wdata   (ram_wdata),
    .ram_rdata   (ram_rdata),
    .ram_busy    (ram_busy)
  );

  instr_ram #(
    .RAM_WORDS (RAM_WORDS),
    .RAM_WAIT  (RAM_WAIT)
  ) ram_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .addr    (ram_addr),
    .ren     (ram_ren),
    .wen     (ram_wen),
    .byte_en (ram_byte_en),
    .wdata   (ram_wdata),
    .rdata   (ram_rdata),
    .busy    (ram_busy)
  );

endmodule

`default_nettype wire

// File: bench/tb_fetch_unit.sv
////////////////////////////////////////////////////////////
// Testbench of the instruction fetch subsystem.
// Runs command lines from a pattern file against the DUT,
// collects fetch/execute records and checks them against
// a reference memory model and the next-PC rules.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

  localparam int PAT_MAX         = 64;
  localparam int CYCLES_PER_LINE = 40;
  localparam int WAIT_MAX        = 40;

  logic        CLK;
  logic        nRST;
  logic        load_en;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  logic        load_busy;
  logic [31:0] brj_addr;
  logic        npc_sel;
  logic [31:0] priv_pc;
  logic        insert_priv_pc;
  logic        if_ex_stall;
  logic        if_ex_flush;
  logic        update_en;
  logic [31:0] update_pc;
  logic        update_taken;
  logic [31:0] update_target;
  logic        fe_token;
  logic [31:0] fe_pc;
  logic [31:0] fe_pc4;
  logic [31:0] fe_instr;
  logic        fe_prediction;
  logic        mal_insn;
  logic [31:0] badaddr;

  // One command per line: opcode, then fields a, b and c.
  logic [99:0] patterns [PAT_MAX];
  // Words written through the load port, by byte address.
  logic [31:0] model [bit [31:0]];

  // Records seen at the DUT output, oldest first.
  logic [31:0] rec_pc_q    [$];
  logic [31:0] rec_pc4_q   [$];
  logic [31:0] rec_instr_q [$];
  logic        rec_pred_q  [$];

  int          errors;
  int          checks;
  int          tests_passed;
  int          tests_failed;
  int          test_start_errors;
  int          cycles;
  int          cycle_limit;
  int          n_lines;
  logic        token_prev;
  logic [31:0] pc_prev;

  fetch_unit dut_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .load_busy      (load_busy),
    .brj_addr       (brj_addr),
    .npc_sel        (npc_sel),
    .priv_pc        (priv_pc),
    .insert_priv_pc (insert_priv_pc),
    .if_ex_stall    (if_ex_stall),
    .if_ex_flush    (if_ex_flush),
    .update_en      (update_en),
    .update_pc      (update_pc),
    .update_taken   (update_taken),
    .update_target  (update_target),
    .fe_token       (fe_token),
    .fe_pc          (fe_pc),
    .fe_pc4         (fe_pc4),
    .fe_instr       (fe_instr),
    .fe_prediction  (fe_prediction),
    .mal_insn       (mal_insn),
    .badaddr        (badaddr)
  );

  // 20 ns clock.
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Watchdog on the total run length.
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Record monitor.
  // A rising token or a new pc under the token is a fresh record.
  always @(negedge CLK) begin
    if (nRST && fe_token && (!token_prev || fe_pc != pc_prev)) begin
      rec_pc_q.push_back(fe_pc);
      rec_pc4_q.push_back(fe_pc4);
      rec_instr_q.push_back(fe_instr);
      rec_pred_q.push_back(fe_prediction);
    end
    token_prev = fe_token;
    pc_prev    = fe_pc;
  end

  // Core sees the memory word with its bytes reversed.
  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Steps to just after the next rising edge.
  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic clear_records();
    rec_pc_q.delete();
    rec_pc4_q.delete();
    rec_instr_q.delete();
    rec_pred_q.delete();
  endtask

  // Load port write, held until the cycle with busy low.
  task automatic load_word(input logic [31:0] addr);
    logic [31:0] data;
    int          n;
    data      = $urandom;
    n         = 0;
    load_en   = 1'b1;
    load_addr = addr;
    load_data = data;
    @(negedge CLK);
    while (load_busy && n < WAIT_MAX) begin
      @(negedge CLK);
      n++;
    end
    if (load_busy) begin
      errors++;
      $display("Load of address %h never completed", addr);
    end
    next_cycle();
    load_en     = 1'b0;
    model[addr] = data;
  endtask

  task automatic expect_record(input logic [31:0] pc, input logic [31:0] pred);
    logic [31:0] exp_instr;
    int          n;
    n = 0;
    while (rec_pc_q.size() == 0 && n < WAIT_MAX) begin
      // Looked at once the monitor has taken this edge's record.
      @(negedge CLK);
      #1;
      n++;
    end
    if (rec_pc_q.size() == 0) begin
      errors++;
      $display("No fetch record arrived while waiting for pc %h", pc);
    end else if (!model.exists(pc)) begin
      errors++;
      $display("Pattern expects pc %h, which was never loaded", pc);
    end else begin
      exp_instr = swap_bytes(model[pc]);
      check_value("record pc", rec_pc_q.pop_front(), pc);
      check_value("record pc4", rec_pc4_q.pop_front(), pc + 32'd4);
      check_value("record instr", rec_instr_q.pop_front(), exp_instr);
      check_value("record prediction", {31'b0, rec_pred_q.pop_front()}, pred);
    end
    next_cycle();
  endtask

  task automatic finish_test(input logic [31:0] num);
    if (errors == test_start_errors) begin
      tests_passed++;
      $display("Test %0d passed", num);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d errors", num, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // Executes one pattern line.
  task automatic run_line(input logic [99:0] line);
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    op = line[99:96];
    a  = line[95:64];
    b  = line[63:32];
    c  = line[31:0];
    case (op)
      4'h1: load_word(a);
      4'h2: begin
        if_ex_stall = a[0];
        next_cycle();
      end
      4'h3: begin
        brj_addr    = a;
        npc_sel     = 1'b1;
        if_ex_flush = b[0];
        next_cycle();
        npc_sel     = 1'b0;
        if_ex_flush = 1'b0;
        clear_records();
      end
      4'h4: begin
        priv_pc        = a;
        brj_addr       = b;
        insert_priv_pc = 1'b1;
        npc_sel        = c[0];
        if_ex_flush    = c[1];
        next_cycle();
        insert_priv_pc = 1'b0;
        npc_sel        = 1'b0;
        if_ex_flush    = 1'b0;
        clear_records();
      end
      4'h5: begin
        update_en     = 1'b1;
        update_pc     = a;
        update_target = b;
        update_taken  = c[0];
        next_cycle();
        update_en     = 1'b0;
      end
      4'h6: expect_record(a, c);
      4'h7: begin
        check_value("mal_insn", {31'b0, mal_insn}, 32'd1);
        check_value("badaddr", badaddr, a);
        next_cycle();
      end
      4'h8: repeat (a) next_cycle();
      4'h9: begin
        check_value("held record pc", fe_pc, a);
        check_value("records during stall", rec_pc_q.size(), 32'd0);
      end
      4'hA: finish_test(a);
      default: begin
        errors++;
        $display("Unknown pattern opcode %h", op);
      end
    endcase
  endtask

  initial begin
    void'($urandom(97));
    errors            = 0;
    checks            = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    test_start_errors = 0;
    cycles            = 0;
    cycle_limit       = 0;
    token_prev        = 1'b0;
    pc_prev           = '0;
    nRST              = 1'b0;
    load_en           = 1'b0;
    load_addr         = '0;
    load_data         = '0;
    brj_addr          = '0;
    npc_sel           = 1'b0;
    priv_pc           = '0;
    insert_priv_pc    = 1'b0;
    // Held from reset so that memory loads before fetching.
    if_ex_stall       = 1'b1;
    if_ex_flush       = 1'b0;
    update_en         = 1'b0;
    update_pc         = '0;
    update_taken      = 1'b0;
    update_target     = '0;
    $readmemh("bench/fetch_patterns.txt", patterns);
    n_lines = 0;
    while (n_lines < PAT_MAX && patterns[n_lines][99:96] !== 4'hF) begin
      n_lines++;
    end
    cycle_limit = CYCLES_PER_LINE * (n_lines + 1);
    repeat (3) @(posedge CLK);
    #2;
    nRST = 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      run_line(patterns[i]);
    end
    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/fetch_patterns.txt
// op_aaaaaaaa_bbbbbbbb_cccccccc, op 1 load a, 2 stall a, 3 redirect a flush b,
// 4 priv a brj b (c0 npc_sel, c1 flush), 5 update pc a target b taken c,
// 6 record pc a pred c, 7 fault a, 8 wait a, 9 held pc a, A end test a, F end
1_00000200_00000000_00000000
1_00000204_00000000_00000000
1_00000208_00000000_00000000
1_0000020C_00000000_00000000
2_00000000_00000000_00000000
6_00000200_00000000_00000000
6_00000204_00000000_00000000
6_00000208_00000000_00000000
6_0000020C_00000000_00000000
A_00000001_00000000_00000000
3_00000200_00000001_00000000
6_00000200_00000000_00000000
1_0000020C_00000000_00000000
6_00000204_00000000_00000000
6_00000208_00000000_00000000
6_0000020C_00000000_00000000
A_00000002_00000000_00000000
1_00000300_00000000_00000000
3_00000300_00000001_00000000
6_00000300_00000000_00000000
A_00000003_00000000_00000000
1_00000240_00000000_00000000
1_00000244_00000000_00000000
1_00000248_00000000_00000000
1_0000024C_00000000_00000000
1_00000280_00000000_00000000
5_00000244_00000280_00000001
5_00000244_00000280_00000001
5_00000248_00000000_00000000
3_00000240_00000001_00000000
6_00000240_00000000_00000000
6_00000244_00000000_00000001
6_00000280_00000000_00000000
3_00000248_00000001_00000000
6_00000248_00000000_00000000
6_0000024C_00000000_00000000
A_00000004_00000000_00000000
1_000002A0_00000000_00000000
4_000002A0_00000300_00000003
6_000002A0_00000000_00000000
4_000002A2_00000000_00000002
7_000002A2_00000000_00000000
A_00000005_00000000_00000000
3_00000200_00000001_00000000
6_00000200_00000000_00000000
2_00000001_00000000_00000000
8_00000006_00000000_00000000
9_00000200_00000000_00000000
2_00000000_00000000_00000000
6_00000204_00000000_00000000
A_00000006_00000000_00000000
F_00000000_00000000_00000000

// File: sources.f
source/rv32i_types_pkg.sv
source/imem_bus_pkg.sv
source/instr_ram.sv
source/imem_arbiter.sv
source/branch_target_buffer.sv
source/fetch_stage.sv
source/fetch_unit.sv
bench/tb_fetch_unit.sv

// File: Makefile
# Verilator simulation of the instruction fetch subsystem.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f \
		--top-module tb_fetch_unit -o sim_fetch_unit
	./obj_dir/sim_fetch_unit | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
